/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --assert --timing
TOP       = dist_network_tb
FILELIST  = project.f

BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

# keep running past assertion errors so the bench prints its summary
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/dist_network_assertions.sv */
`timescale 1ns/10ps

module dist_network_assertions
    import tree_cfg_pkg::*, dist_cmd_pkg::*;
(
    input logic                                  CLK,
    input logic                                  i_reset,
    input logic                                  i_req_valid,
    input logic [MODE_WIDTH-1:0]                 i_req_mode,
    input logic [LEAF_IDX_WIDTH-1:0]             i_req_dest,
    input logic [COUNT_WIDTH-1:0]                i_req_count,
    input logic [NUM_LEAVES-1:0]                 i_req_mask,
    input logic [DATA_WIDTH-1:0]                 i_req_data,
    input logic [NUM_LEAVES-1:0][DATA_WIDTH-1:0] o_leaf_operand,
    input logic [NUM_LEAVES-1:0]                 o_leaf_update,
    input logic [NUM_LEAVES-1:0]                 o_leaf_loaded
);

    // one slot past the pipeline, outputs are sampled a tick after they change
    localparam int DEPTH = DIST_LATENCY + 1;

    logic [NUM_LEAVES-1:0] mask_hist [DEPTH];
    logic [DATA_WIDTH-1:0] data_hist [DEPTH];
    logic                  reset_q  = 1'b0;
    logic                  reset_q2 = 1'b0;
    int                    fail_count = 0;

    function automatic logic [NUM_LEAVES-1:0] expected_mask(
        input logic [MODE_WIDTH-1:0]     mode,
        input logic [LEAF_IDX_WIDTH-1:0] dest,
        input logic [COUNT_WIDTH-1:0]    count,
        input logic [NUM_LEAVES-1:0]     mask
    );
        logic [31:0]           run;
        logic [NUM_LEAVES-1:0] result;
        // run of count ones, shifted up to dest, bits past the top leaf fall off
        run = (32'd1 << count) - 32'd1;
        case (mode)
            MODE_UNICAST:   result = NUM_LEAVES'(32'd1 << dest);
            MODE_MULTICAST: result = mask;
            MODE_BROADCAST: result = '1;
            default:        result = NUM_LEAVES'(run << dest);
        endcase
        return result;
    endfunction

    always @(posedge CLK)
    begin
        reset_q  <= i_reset;
        reset_q2 <= reset_q;
        data_hist[0] <= i_req_data;
        for (int d = 1; d < DEPTH; d++)
        begin
            data_hist[d] <= data_hist[d-1];
        end
        if (i_reset)
        begin
            for (int d = 0; d < DEPTH; d++)
            begin
                mask_hist[d] <= '0;
            end
        end
        else
        begin
            mask_hist[0] <= i_req_valid ?
                expected_mask(i_req_mode, i_req_dest, i_req_count, i_req_mask) : '0;
            for (int d = 1; d < DEPTH; d++)
            begin
                mask_hist[d] <= mask_hist[d-1];
            end
        end
    end

    // control outputs quiet in reset and in the cycle after it
    assert property (@(posedge CLK) (reset_q || reset_q2) |->
        (o_leaf_update == '0 && o_leaf_loaded == '0 && o_leaf_operand == '0))
    else
    begin
        $error("outputs not cleared around reset, update %h loaded %h",
            $sampled(o_leaf_update), $sampled(o_leaf_loaded));
        fail_count++;
    end

    assert property (@(posedge CLK) disable iff (i_reset || reset_q)
        o_leaf_update == mask_hist[DEPTH-1])
    else
    begin
        $error("update mask %h, expected %h",
            $sampled(o_leaf_update), $sampled(mask_hist[DEPTH-1]));
        fail_count++;
    end

    for (genvar k = 0; k < NUM_LEAVES; k++)
    begin : g_leaf
        assert property (@(posedge CLK) disable iff (i_reset || reset_q)
            o_leaf_update[k] |-> o_leaf_operand[k] == data_hist[DEPTH-1])
        else
        begin
            $error("leaf %0d loaded %h, expected %h", k,
                $sampled(o_leaf_operand[k]), $sampled(data_hist[DEPTH-1]));
            fail_count++;
        end

        // stationary operand holds without a command bit
        assert property (@(posedge CLK) disable iff (i_reset || reset_q)
            !o_leaf_update[k] |-> o_leaf_operand[k] == $past(o_leaf_operand[k]))
        else
        begin
            $error("leaf %0d operand changed without an update", k);
            fail_count++;
        end
    end

endmodule

/* bench/dist_network_tb.sv */
`timescale 1ns/10ps

module dist_network_tb
    import tree_cfg_pkg::*, dist_cmd_pkg::*;
;

    localparam int RESET_CYCLES = 16;
    localparam int NUM_TESTS    = 6;
    // unicast, multicast set, ranges, back-to-back, gaps count double
    localparam int REQ_CYCLES     = 16 + 10 + 6 + 20 + 2 * 10;
    localparam int EST_CYCLES     = RESET_CYCLES + REQ_CYCLES + NUM_TESTS * (DIST_LATENCY + 2);
    localparam int TIMEOUT_CYCLES = 10 * EST_CYCLES;

    logic                                  CLK = 1'b0;
    logic                                  reset;
    logic                                  req_valid;
    logic [MODE_WIDTH-1:0]                 req_mode;
    logic [LEAF_IDX_WIDTH-1:0]             req_dest;
    logic [COUNT_WIDTH-1:0]                req_count;
    logic [NUM_LEAVES-1:0]                 req_mask;
    logic [DATA_WIDTH-1:0]                 req_data;
    logic [NUM_LEAVES-1:0][DATA_WIDTH-1:0] leaf_operand;
    logic [NUM_LEAVES-1:0]                 leaf_update;
    logic [NUM_LEAVES-1:0]                 leaf_loaded;

    // expected final state of the leaf bank
    logic [DATA_WIDTH-1:0] model_operand [NUM_LEAVES];
    logic [NUM_LEAVES-1:0] model_loaded;
    logic [31:0]           rng_state = 32'd15;
    int                    bench_errors = 0;
    int                    tests_run = 0;
    int                    seen_assert_fails = 0;
    int                    cycle_count = 0;

    dist_network_top dut_i (
        .CLK            (CLK),
        .i_reset        (reset),
        .i_req_valid    (req_valid),
        .i_req_mode     (req_mode),
        .i_req_dest     (req_dest),
        .i_req_count    (req_count),
        .i_req_mask     (req_mask),
        .i_req_data     (req_data),
        .o_leaf_operand (leaf_operand),
        .o_leaf_update  (leaf_update),
        .o_leaf_loaded  (leaf_loaded)
    );

    bind dist_network_top dist_network_assertions checks_i (.*);

    always #20 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("tests failed");
            $finish;
        end
    end

    // LCG step returning the upper half of the state
    function automatic logic [15:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];
    endfunction

    function automatic logic [DATA_WIDTH-1:0] random_word();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = next_random();
        lo = next_random();
        return {hi, lo};
    endfunction

    function automatic logic [NUM_LEAVES-1:0] leaf_mask_for(
        input logic [MODE_WIDTH-1:0]     mode,
        input logic [LEAF_IDX_WIDTH-1:0] dest,
        input logic [COUNT_WIDTH-1:0]    count,
        input logic [NUM_LEAVES-1:0]     mask
    );
        logic [NUM_LEAVES-1:0] m;
        int                    last;
        m = '0;
        case (mode)
            MODE_UNICAST:   m[dest] = 1'b1;
            MODE_MULTICAST: m = mask;
            MODE_BROADCAST: m = '1;
            default:
            begin
                last = int'(dest) + int'(count) - 1;
                if (last > NUM_LEAVES - 1)
                begin
                    last = NUM_LEAVES - 1;
                end
                for (int i = int'(dest); i <= last; i++)
                begin
                    m[i] = 1'b1;
                end
            end
        endcase
        return m;
    endfunction

    task automatic send_request(
        input logic [MODE_WIDTH-1:0]     mode,
        input logic [LEAF_IDX_WIDTH-1:0] dest,
        input logic [COUNT_WIDTH-1:0]    count,
        input logic [NUM_LEAVES-1:0]     mask,
        input logic [DATA_WIDTH-1:0]     data
    );
        logic [NUM_LEAVES-1:0] sel;
        sel = leaf_mask_for(mode, dest, count, mask);
        @(negedge CLK);
        req_valid = 1'b1;
        req_mode  = mode;
        req_dest  = dest;
        req_count = count;
        req_mask  = mask;
        req_data  = data;
        for (int k = 0; k < NUM_LEAVES; k++)
        begin
            if (sel[k])
            begin
                model_operand[k] = data;
            end
        end
        model_loaded = model_loaded | sel;
    endtask

    task automatic send_random_request();
        logic [15:0] r;
        r = next_random();
        send_request(r[1:0], r[5:2], r[10:6], next_random(), random_word());
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge CLK);
            req_valid = 1'b0;
        end
    endtask

    // drain the pipeline, then compare the bank with the model
    task automatic finish_test(input string name);
        int mismatches;
        int new_fails;
        idle_cycles(DIST_LATENCY + 2);
        mismatches = 0;
        for (int k = 0; k < NUM_LEAVES; k++)
        begin
            if (leaf_operand[k] !== model_operand[k])
            begin
                $display("** Error at %0d ns: leaf %0d operand %h, expected %h",
                    $time, k, leaf_operand[k], model_operand[k]);
                mismatches++;
            end
        end
        if (leaf_loaded !== model_loaded)
        begin
            $display("** Error at %0d ns: loaded flags %h, expected %h",
                $time, leaf_loaded, model_loaded);
            mismatches++;
        end
        new_fails = dut_i.checks_i.fail_count - seen_assert_fails;
        seen_assert_fails = dut_i.checks_i.fail_count;
        bench_errors += mismatches;
        tests_run++;
        $display("test %s finished: %0d mismatches, %0d assertion failures",
            name, mismatches, new_fails);
    endtask

    initial
    begin
        reset     = 1'b1;
        req_valid = 1'b0;
        req_mode  = MODE_UNICAST;
        req_dest  = '0;
        req_count = '0;
        req_mask  = '0;
        req_data  = '0;
        model_loaded = '0;
        for (int k = 0; k < NUM_LEAVES; k++)
        begin
            model_operand[k] = '0;
        end

        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;
        finish_test("reset");

        for (int k = 0; k < NUM_LEAVES; k++)
        begin
            send_request(MODE_UNICAST, LEAF_IDX_WIDTH'(k), '0, '0, random_word());
        end
        finish_test("unicast");

        repeat (8)
        begin
            send_request(MODE_MULTICAST, '0, '0, next_random(), random_word());
        end
        // empty mask touches nothing
        send_request(MODE_MULTICAST, '0, '0, '0, random_word());
        send_request(MODE_BROADCAST, '0, '0, '0, random_word());
        finish_test("multicast");

        send_request(MODE_RANGE, 4'd2, 5'd5, '0, random_word());
        send_request(MODE_RANGE, 4'd12, 5'd4, '0, random_word());
        send_request(MODE_RANGE, 4'd13, 5'd9, '0, random_word());
        send_request(MODE_RANGE, 4'd15, 5'd16, '0, random_word());
        send_request(MODE_RANGE, 4'd0, 5'd16, '0, random_word());
        send_request(MODE_RANGE, 4'd7, 5'd0, '0, random_word());
        finish_test("range");

        repeat (20)
        begin
            send_random_request();
        end
        finish_test("back_to_back");

        repeat (10)
        begin
            send_random_request();
            idle_cycles(1);
        end
        finish_test("gaps");

        $display("%0d tests run, %0d mismatches, %0d assertion failures",
            tests_run, bench_errors, dut_i.checks_i.fail_count);
        if (bench_errors == 0 && dut_i.checks_i.fail_count == 0)
        begin
            $display("all tests passed");
        end
        else
        begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* logic/cmd_wire_tree.sv */
`timescale 1ns/10ps

module cmd_wire_tree
    import tree_cfg_pkg::*;
(
    input  logic                  CLK,
    input  logic                  i_reset,
    input  logic                  i_en,
    input  logic [NUM_LEAVES-1:0] i_cmd,
    output logic [NUM_LEAVES-1:0] o_leaf_cmd
);

    // each level is stored as one vector holding all of its nodes side by side
    // node j of level l sits at [j*W +: W] with W = NUM_LEAVES >> l
    logic [NUM_LEAVES-1:0] level_q [NUM_LEVELS];

    // root keeps the whole mask, gated by the enable
    always_ff @(posedge CLK)
    begin
        if (i_reset)
        begin
            level_q[0] <= '0;
        end
        else if (i_en)
        begin
            level_q[0] <= i_cmd;
        end
        else
        begin
            level_q[0] <= '0;
        end
    end

    genvar l, j;
    generate
        for (l = 1; l < NUM_LEVELS; l++)
        begin : g_level
            localparam int W     = NUM_LEAVES >> l;
            localparam int PW    = W * 2;
            localparam int NODES = 1 << l;

            for (j = 0; j < NODES; j++)
            begin : g_node
                // even child takes the lower half of its parent, odd the upper
                localparam int PARENT = j / 2;
                localparam int HALF   = j % 2;

                always_ff @(posedge CLK)
                begin
                    if (i_reset)
                    begin
                        level_q[l][j*W +: W] <= '0;
                    end
                    else
                    begin
                        level_q[l][j*W +: W] <= level_q[l-1][PARENT*PW + HALF*W +: W];
                    end
                end
            end
        end

        // last level nodes are two bits wide, split them into single leaf bits
        for (j = 0; j < NUM_LEAVES; j++)
        begin : g_leaf
            always_ff @(posedge CLK)
            begin
                if (i_reset)
                begin
                    o_leaf_cmd[j] <= 1'b0;
                end
                else
                begin
                    o_leaf_cmd[j] <= level_q[NUM_LEVELS-1][(j/2)*2 + (j%2)];
                end
            end
        end
    endgenerate

endmodule

/* logic/data_dist_tree.sv */
`timescale 1ns/10ps

module data_dist_tree
    import tree_cfg_pkg::*;
(
    input  logic                                  CLK,
    input  logic [DATA_WIDTH-1:0]                 i_data,
    output logic [NUM_LEAVES-1:0][DATA_WIDTH-1:0] o_leaf_data
);

    // heap numbering, node 1 is the root and node n feeds 2n and 2n+1
    // nodes 1 to NUM_LEAVES-1 cover levels 0 to NUM_LEVELS-1
    logic [DATA_WIDTH-1:0] node_q [1:NUM_LEAVES-1];

    always_ff @(posedge CLK)
    begin
        node_q[1] <= i_data;
    end

    genvar n, k;
    generate
        for (n = 2; n < NUM_LEAVES; n++)
        begin : g_node
            // every register drives exactly two children
            always_ff @(posedge CLK)
            begin
                node_q[n] <= node_q[n/2];
            end
        end

        // output stage
        // leaf k is heap node NUM_LEAVES+k, so its parent is the last level
        for (k = 0; k < NUM_LEAVES; k++)
        begin : g_leaf
            always_ff @(posedge CLK)
            begin
                o_leaf_data[k] <= node_q[(NUM_LEAVES + k) / 2];
            end
        end
    endgenerate

endmodule

/* logic/dist_cmd_decoder.sv */
`timescale 1ns/10ps

module dist_cmd_decoder
    import tree_cfg_pkg::*, dist_cmd_pkg::*;
(
    input  logic                      CLK,
    input  logic                      i_reset,
    input  logic                      i_req_valid,
    input  logic [MODE_WIDTH-1:0]     i_req_mode,
    input  logic [LEAF_IDX_WIDTH-1:0] i_req_dest,
    input  logic [COUNT_WIDTH-1:0]    i_req_count,
    input  logic [NUM_LEAVES-1:0]     i_req_mask,
    input  logic [DATA_WIDTH-1:0]     i_req_data,
    output logic                      o_cmd_valid,
    output logic [NUM_LEAVES-1:0]     o_cmd_mask,
    output logic [DATA_WIDTH-1:0]     o_cmd_data
);

    logic [NUM_LEAVES-1:0]  req_mask;
    logic [COUNT_WIDTH:0]   range_end;

    // first leaf past the range, may point beyond leaf 15
    assign range_end = (COUNT_WIDTH+1)'(i_req_dest) + (COUNT_WIDTH+1)'(i_req_count);

    always_comb
    begin
        req_mask = '0;
        case (i_req_mode)
            MODE_UNICAST:
            begin
                req_mask[i_req_dest] = 1'b1;
            end
            MODE_MULTICAST:
            begin
                req_mask = i_req_mask;
            end
            MODE_BROADCAST:
            begin
                req_mask = '1;
            end
            default:
            begin
                // clipping at the top leaf falls out of the loop bound
                for (int i = 0; i < NUM_LEAVES; i++)
                begin
                    req_mask[i] = (i >= int'(i_req_dest)) && (i < int'(range_end));
                end
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (i_reset)
        begin
            o_cmd_valid <= 1'b0;
            o_cmd_mask  <= '0;
        end
        else
        begin
            o_cmd_valid <= i_req_valid;
            o_cmd_mask  <= i_req_valid ? req_mask : '0;
        end
    end

    // payload only matters under a mask bit
    always_ff @(posedge CLK)
    begin
        o_cmd_data <= i_req_data;
    end

endmodule

/* logic/dist_cmd_pkg.sv */
package dist_cmd_pkg;

    // request mode field
    localparam int MODE_WIDTH = 2;

    // one leaf, picked by i_req_dest
    localparam logic [MODE_WIDTH-1:0] MODE_UNICAST = 2'd0;

    // arbitrary leaf set, taken from i_req_mask
    localparam logic [MODE_WIDTH-1:0] MODE_MULTICAST = 2'd1;

    // every leaf
    localparam logic [MODE_WIDTH-1:0] MODE_BROADCAST = 2'd2;

    // contiguous run starting at i_req_dest, i_req_count leaves long
    localparam logic [MODE_WIDTH-1:0] MODE_RANGE = 2'd3;

    // range length
    // one bit wider than a leaf index so a run can cover all leaves
    localparam int COUNT_WIDTH = 5;

endpackage

/* logic/dist_network_top.sv */
`timescale 1ns/10ps

module dist_network_top
    import tree_cfg_pkg::*, dist_cmd_pkg::*;
(
    input  logic                                  CLK,
    input  logic                                  i_reset,
    input  logic                                  i_req_valid,
    input  logic [MODE_WIDTH-1:0]                 i_req_mode,
    input  logic [LEAF_IDX_WIDTH-1:0]             i_req_dest,
    input  logic [COUNT_WIDTH-1:0]                i_req_count,
    input  logic [NUM_LEAVES-1:0]                 i_req_mask,
    input  logic [DATA_WIDTH-1:0]                 i_req_data,
    output logic [NUM_LEAVES-1:0][DATA_WIDTH-1:0] o_leaf_operand,
    output logic [NUM_LEAVES-1:0]                 o_leaf_update,
    output logic [NUM_LEAVES-1:0]                 o_leaf_loaded
);

    logic                                  cmd_valid;
    logic [NUM_LEAVES-1:0]                 cmd_mask;
    logic [DATA_WIDTH-1:0]                 cmd_data;
    logic [NUM_LEAVES-1:0]                 leaf_cmd;
    logic [NUM_LEAVES-1:0][DATA_WIDTH-1:0] leaf_data;

    dist_cmd_decoder decoder_i (
        .CLK         (CLK),
        .i_reset     (i_reset),
        .i_req_valid (i_req_valid),
        .i_req_mode  (i_req_mode),
        .i_req_dest  (i_req_dest),
        .i_req_count (i_req_count),
        .i_req_mask  (i_req_mask),
        .i_req_data  (i_req_data),
        .o_cmd_valid (cmd_valid),
        .o_cmd_mask  (cmd_mask),
        .o_cmd_data  (cmd_data)
    );

    // both trees have the same depth, so mask bits and words reach the leaves together
    cmd_wire_tree cmd_tree_i (
        .CLK        (CLK),
        .i_reset    (i_reset),
        .i_en       (cmd_valid),
        .i_cmd      (cmd_mask),
        .o_leaf_cmd (leaf_cmd)
    );

    data_dist_tree data_tree_i (
        .CLK         (CLK),
        .i_data      (cmd_data),
        .o_leaf_data (leaf_data)
    );

    leaf_operand_bank leaf_bank_i (
        .CLK            (CLK),
        .i_reset        (i_reset),
        .i_leaf_cmd     (leaf_cmd),
        .i_leaf_data    (leaf_data),
        .o_leaf_operand (o_leaf_operand),
        .o_leaf_update  (o_leaf_update),
        .o_leaf_loaded  (o_leaf_loaded)
    );

endmodule

/* logic/leaf_operand_bank.sv */
`timescale 1ns/10ps

module leaf_operand_bank
    import tree_cfg_pkg::*;
(
    input  logic                                  CLK,
    input  logic                                  i_reset,
    input  logic [NUM_LEAVES-1:0]                 i_leaf_cmd,
    input  logic [NUM_LEAVES-1:0][DATA_WIDTH-1:0] i_leaf_data,
    output logic [NUM_LEAVES-1:0][DATA_WIDTH-1:0] o_leaf_operand,
    output logic [NUM_LEAVES-1:0]                 o_leaf_update,
    output logic [NUM_LEAVES-1:0]                 o_leaf_loaded
);

    // stationary operands
    // a leaf keeps its word until the next command that selects it
    always_ff @(posedge CLK)
    begin
        if (i_reset)
        begin
            o_leaf_operand <= '0;
        end
        else
        begin
            for (int k = 0; k < NUM_LEAVES; k++)
            begin
                if (i_leaf_cmd[k])
                begin
                    o_leaf_operand[k] <= i_leaf_data[k];
                end
            end
        end
    end

    // update strobe lines up with the new operand
    // loaded flag is sticky until reset
    always_ff @(posedge CLK)
    begin
        if (i_reset)
        begin
            o_leaf_update <= '0;
            o_leaf_loaded <= '0;
        end
        else
        begin
            o_leaf_update <= i_leaf_cmd;
            o_leaf_loaded <= o_leaf_loaded | i_leaf_cmd;
        end
    end

endmodule

/* logic/tree_cfg_pkg.sv */
package tree_cfg_pkg;

    // leaves of the distribution tree, one per multiplier
    localparam int NUM_LEAVES = 16;

    // binary tree depth
    localparam int NUM_LEVELS = $clog2(NUM_LEAVES);

    // operand word carried to each leaf
    localparam int DATA_WIDTH = 32;

    // enough bits to name any single leaf
    localparam int LEAF_IDX_WIDTH = $clog2(NUM_LEAVES);

    // register stages inside each tree
    // one per level plus the per-leaf output stage
    localparam int TREE_LATENCY = NUM_LEVELS + 1;

    // request edge to leaf update edge
    // decoder stage, tree stages, then the leaf bank itself is the last edge
    localparam int DIST_LATENCY = 1 + TREE_LATENCY;

endpackage

/* project.f */
logic/tree_cfg_pkg.sv
logic/dist_cmd_pkg.sv
logic/dist_cmd_decoder.sv
logic/cmd_wire_tree.sv
logic/data_dist_tree.sv
logic/leaf_operand_bank.sv
logic/dist_network_top.sv
bench/dist_network_assertions.sv
bench/dist_network_tb.sv
